// File: project.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/alu.sv
rtl/issue_steer.sv
rtl/exec_lane.sv
rtl/register_file.sv
rtl/dual_issue_core.sv
verif/core_tb.sv

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
  input  isa_pkg::alu_op_e alu_op,
  input  isa_pkg::word_t   a,
  input  isa_pkg::word_t   b,
  output isa_pkg::word_t   y
);

  always_comb begin
    case (alu_op)
      isa_pkg::alu_add: begin
        y = a + b;
      end
      isa_pkg::alu_sub: begin
        y = a - b;
      end
      isa_pkg::alu_and: begin
        y = a & b;
      end
      isa_pkg::alu_or: begin
        y = a | b;
      end
      isa_pkg::alu_xor: begin
        y = a ^ b;
      end
      isa_pkg::alu_slt: begin
        // signed compare, result is 1 or 0
        y = isa_pkg::word_t'($signed(a) < $signed(b));
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

// File: rtl/dual_issue_core.sv
`timescale 1ns/1ps

`include "proc_defines.svh"

module dual_issue_core (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      bundle_valid,
  input  isa_pkg::inst_t [`PROC_NUM_LANES-1:0]      bundle,
  output logic                                      issue_stall,
  output pipe_pkg::wb_result_t [`PROC_NUM_LANES-1:0] wb
);

  pipe_pkg::issue_slot_t [`PROC_NUM_LANES-1:0]   slots;
  pipe_pkg::operand_req_t [`PROC_NUM_LANES-1:0]  rd_req;
  pipe_pkg::operand_data_t [`PROC_NUM_LANES-1:0] rd_data;

  issue_steer steer0 (
    .clk          (clk),
    .reset        (reset),
    .bundle_valid (bundle_valid),
    .bundle       (bundle),
    .issue_stall  (issue_stall),
    .slots        (slots)
  );

  //////////////////////////////////////////////////////////////////////
  // lanes, every lane sees all result registers for forwarding
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `PROC_NUM_LANES; g++) begin : g_lane
    exec_lane lane (
      .clk     (clk),
      .reset   (reset),
      .slot    (slots[g]),
      .rd_req  (rd_req[g]),
      .rd_data (rd_data[g]),
      .fwd     (wb),
      .result  (wb[g])
    );
  end

  register_file regfile0 (
    .clk     (clk),
    .reset   (reset),
    .rd_req  (rd_req),
    .rd_data (rd_data),
    .wb      (wb)
  );

endmodule

// File: rtl/exec_lane.sv
`timescale 1ns/1ps

`include "proc_defines.svh"

module exec_lane (
  input  logic                                     clk,
  input  logic                                     reset,
  input  pipe_pkg::issue_slot_t                    slot,
  output pipe_pkg::operand_req_t                   rd_req,
  input  pipe_pkg::operand_data_t                  rd_data,
  input  pipe_pkg::wb_result_t [`PROC_NUM_LANES-1:0] fwd,
  output pipe_pkg::wb_result_t                     result
);

  isa_pkg::opcode_e   dec_op;
  isa_pkg::alu_op_e   dec_alu_op;
  logic               dec_use_imm;
  isa_pkg::reg_addr_t dec_dest;

  logic               ex_write;
  isa_pkg::alu_op_e   ex_alu_op;
  logic               ex_use_imm;
  isa_pkg::reg_addr_t ex_rs;
  isa_pkg::reg_addr_t ex_rt;
  isa_pkg::reg_addr_t ex_dest;
  isa_pkg::imm_t      ex_imm;
  isa_pkg::word_t     ex_rs_data;
  isa_pkg::word_t     ex_rt_data;

  isa_pkg::word_t     op_a;
  isa_pkg::word_t     op_b;
  isa_pkg::word_t     alu_b;
  isa_pkg::word_t     alu_y;

  //////////////////////////////////////////////////////////////////////
  // register read stage
  //////////////////////////////////////////////////////////////////////

  assign rd_req.rs = slot.inst[25:21];
  assign rd_req.rt = slot.inst[20:16];

  always_comb begin
    dec_op      = isa_pkg::inst_op(slot.inst);
    dec_use_imm = isa_pkg::is_itype(dec_op);
    dec_dest    = isa_pkg::inst_dest(slot.inst);
    case (dec_op)
      isa_pkg::op_sub: dec_alu_op = isa_pkg::alu_sub;
      isa_pkg::op_and: dec_alu_op = isa_pkg::alu_and;
      isa_pkg::op_or,
      isa_pkg::op_ori: dec_alu_op = isa_pkg::alu_or;
      isa_pkg::op_xor: dec_alu_op = isa_pkg::alu_xor;
      isa_pkg::op_slt: dec_alu_op = isa_pkg::alu_slt;
      default:         dec_alu_op = isa_pkg::alu_add;
    endcase
  end

  // operand register
  always_ff @(posedge clk) begin
    ex_alu_op  <= dec_alu_op;
    ex_use_imm <= dec_use_imm;
    ex_rs      <= rd_req.rs;
    ex_rt      <= rd_req.rt;
    ex_dest    <= dec_dest;
    ex_imm     <= slot.inst[15:0];
    ex_rs_data <= rd_data.rs_data;
    ex_rt_data <= rd_data.rt_data;
    if (reset)
      ex_write <= 1'b0;
    else
      ex_write <= slot.valid && dec_dest != '0;
  end

  //////////////////////////////////////////////////////////////////////
  // execute stage
  //////////////////////////////////////////////////////////////////////

  // higher lane is younger and overrides
  always_comb begin
    op_a = ex_rs_data;
    op_b = ex_rt_data;
    for (int i = 0; i < `PROC_NUM_LANES; i++) begin
      if (fwd[i].valid && fwd[i].rd != '0 && fwd[i].rd == ex_rs)
        op_a = fwd[i].data;
      if (fwd[i].valid && fwd[i].rd != '0 && fwd[i].rd == ex_rt)
        op_b = fwd[i].data;
    end
  end

  // immediate is zero extended
  assign alu_b = ex_use_imm ? isa_pkg::word_t'(ex_imm) : op_b;

  alu alu0 (
    .alu_op (ex_alu_op),
    .a      (op_a),
    .b      (alu_b),
    .y      (alu_y)
  );

  // result register
  always_ff @(posedge clk) begin
    result.rd   <= ex_dest;
    result.data <= alu_y;
    if (reset)
      result.valid <= 1'b0;
    else
      result.valid <= ex_write;
  end

  // results of every lane reach the forwarding muxes
  for (genvar g = 0; g < `PROC_NUM_LANES; g++) begin : g_fwd_check
    assert property (@(posedge clk) disable iff (reset) fwd[g].valid |-> fwd[g].rd != '0);
  end

endmodule

// File: rtl/isa_pkg.sv
`include "proc_defines.svh"

package isa_pkg;

  typedef logic [`PROC_DATA_WIDTH-1:0]     word_t;
  typedef logic [`PROC_REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`PROC_INST_WIDTH-1:0]     inst_t;
  typedef logic [15:0]                     imm_t;

  // codes not listed here decode as no-ops
  typedef enum logic [5:0] {
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    op_slt  = 6'h06,
    op_addi = 6'h08,
    op_ori  = 6'h0d
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_slt = 3'd5
  } alu_op_e;

  function automatic opcode_e inst_op(inst_t inst);
    return opcode_e'(inst[31:26]);
  endfunction

  function automatic logic is_rtype(opcode_e op);
    return op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt};
  endfunction

  function automatic logic is_itype(opcode_e op);
    return op inside {op_addi, op_ori};
  endfunction

  // r0 when the instruction writes nothing
  function automatic reg_addr_t inst_dest(inst_t inst);
    reg_addr_t dest;
    dest = '0;
    if (is_rtype(inst_op(inst)))
      dest = inst[15:11];
    else if (is_itype(inst_op(inst)))
      dest = inst[20:16];
    return dest;
  endfunction

endpackage

// File: rtl/issue_steer.sv
`timescale 1ns/1ps

`include "proc_defines.svh"

module issue_steer (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      bundle_valid,
  input  isa_pkg::inst_t [`PROC_NUM_LANES-1:0]      bundle,
  output logic                                      issue_stall,
  output pipe_pkg::issue_slot_t [`PROC_NUM_LANES-1:0] slots
);

  typedef enum logic {
    steer_pass,
    steer_replay
  } steer_state_e;

  steer_state_e       state;
  isa_pkg::inst_t     held_inst;
  isa_pkg::opcode_e   op1;
  isa_pkg::reg_addr_t dest0;
  logic               reads_dest;
  logic               accept;
  logic               split;

  //////////////////////////////////////////////////////////////////////
  // dependency check, slot 1 sources against slot 0 destination
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    op1   = isa_pkg::inst_op(bundle[1]);
    dest0 = isa_pkg::inst_dest(bundle[0]);
    reads_dest = 1'b0;
    if ((isa_pkg::is_rtype(op1) || isa_pkg::is_itype(op1)) && bundle[1][25:21] == dest0)
      reads_dest = 1'b1;
    if (isa_pkg::is_rtype(op1) && bundle[1][20:16] == dest0)
      reads_dest = 1'b1;
  end

  assign issue_stall = (state == steer_replay);
  assign accept      = bundle_valid && !issue_stall;
  // r0 never carries a dependency
  assign split       = accept && dest0 != '0 && reads_dest;

  //////////////////////////////////////////////////////////////////////
  // slot registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= steer_pass;
      slots[0].valid <= 1'b0;
      slots[1].valid <= 1'b0;
    end else if (state == steer_replay) begin
      // deferred instruction goes out alone in lane 0
      slots[0]       <= '{valid: 1'b1, inst: held_inst};
      slots[1].valid <= 1'b0;
      state          <= steer_pass;
    end else begin
      slots[0] <= '{valid: accept, inst: bundle[0]};
      slots[1] <= '{valid: accept && !split, inst: bundle[1]};
      if (split)
        state <= steer_replay;
    end
  end

  always_ff @(posedge clk) begin
    if (split)
      held_inst <= bundle[1];
  end

  // a split costs exactly one bubble
  assert property (@(posedge clk) disable iff (reset) issue_stall |=> !issue_stall);

endmodule

// File: rtl/pipe_pkg.sv
package pipe_pkg;

  // steer to lane
  typedef struct packed {
    logic           valid;
    isa_pkg::inst_t inst;
  } issue_slot_t;

  // lane to register file, read addresses
  typedef struct packed {
    isa_pkg::reg_addr_t rs;
    isa_pkg::reg_addr_t rt;
  } operand_req_t;

  // register file to lane, same cycle as the request
  typedef struct packed {
    isa_pkg::word_t rs_data;
    isa_pkg::word_t rt_data;
  } operand_data_t;

  // lane result register
  // feeds both the forwarding muxes and the write ports
  typedef struct packed {
    logic               valid;
    isa_pkg::reg_addr_t rd;
    isa_pkg::word_t     data;
  } wb_result_t;

endpackage

// File: rtl/proc_defines.svh
`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

// datapath
`define PROC_DATA_WIDTH 32
`define PROC_INST_WIDTH 32

// register file
`define PROC_NUM_REGS 32
`define PROC_REG_ADDR_WIDTH 5

// issue width, slot 0 is the older instruction
`define PROC_NUM_LANES 2

`endif

// File: rtl/register_file.sv
`timescale 1ns/1ps

`include "proc_defines.svh"

module register_file (
  input  logic                                        clk,
  input  logic                                        reset,
  input  pipe_pkg::operand_req_t [`PROC_NUM_LANES-1:0]  rd_req,
  output pipe_pkg::operand_data_t [`PROC_NUM_LANES-1:0] rd_data,
  input  pipe_pkg::wb_result_t [`PROC_NUM_LANES-1:0]    wb
);

  isa_pkg::word_t regs [`PROC_NUM_REGS];

  // write-through, later lane wins, r0 pinned to zero
  function automatic isa_pkg::word_t read_port(isa_pkg::reg_addr_t addr);
    isa_pkg::word_t val;
    val = regs[addr];
    for (int i = 0; i < `PROC_NUM_LANES; i++) begin
      if (wb[i].valid && wb[i].rd == addr)
        val = wb[i].data;
    end
    if (addr == '0)
      val = '0;
    return val;
  endfunction

  always_comb begin
    for (int p = 0; p < `PROC_NUM_LANES; p++) begin
      rd_data[p].rs_data = read_port(rd_req[p].rs);
      rd_data[p].rt_data = read_port(rd_req[p].rt);
    end
  end

  // two write ports, lane 1 written last
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < `PROC_NUM_REGS; r++)
        regs[r] <= '0;
    end else begin
      for (int i = 0; i < `PROC_NUM_LANES; i++) begin
        if (wb[i].valid && wb[i].rd != '0)
          regs[wb[i].rd] <= wb[i].data;
      end
    end
  end

  for (genvar g = 0; g < `PROC_NUM_LANES; g++) begin : g_wr_check
    assert property (@(posedge clk) disable iff (reset) wb[g].valid |-> wb[g].rd != '0);
  end

endmodule

// File: verif/core_tb.sv
`timescale 1ns/1ps

`include "proc_defines.svh"

module core_tb;

  localparam int RANDOM_PAIRS   = 300;
  // pairs sent by the four directed tests
  localparam int DIRECTED_PAIRS = 18;
  localparam int TOTAL_INSTS    = 2 * (RANDOM_PAIRS + DIRECTED_PAIRS);
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_INSTS + 100;

  typedef struct packed {
    isa_pkg::reg_addr_t rd;
    isa_pkg::word_t     data;
    logic [31:0]        due;
  } expected_write_t;

  logic                                       clk;
  logic                                       reset;
  logic                                       bundle_valid;
  isa_pkg::inst_t [`PROC_NUM_LANES-1:0]       bundle;
  logic                                       issue_stall;
  pipe_pkg::wb_result_t [`PROC_NUM_LANES-1:0] wb;

  isa_pkg::word_t  model_regs [`PROC_NUM_REGS];
  expected_write_t exp_q [$];
  int unsigned     cycle = 0;
  logic            stall_due;
  string           test_name;
  int              errors;
  int              checks;
  int              tests_run;
  int              test_errors0;
  int              test_checks0;

  dual_issue_core dut0 (
    .clk          (clk),
    .reset        (reset),
    .bundle_valid (bundle_valid),
    .bundle       (bundle),
    .issue_stall  (issue_stall),
    .wb           (wb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the pipeline never drained", cycle);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // r0 for anything that writes nothing
  function automatic isa_pkg::reg_addr_t dest_of(isa_pkg::inst_t inst);
    case (inst[31:26])
      isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and,
      isa_pkg::op_or, isa_pkg::op_xor, isa_pkg::op_slt: return inst[15:11];
      isa_pkg::op_addi, isa_pkg::op_ori: return inst[20:16];
      default: return '0;
    endcase
  endfunction

  function automatic logic reads_reg(isa_pkg::inst_t inst, isa_pkg::reg_addr_t r);
    case (inst[31:26])
      isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and,
      isa_pkg::op_or, isa_pkg::op_xor, isa_pkg::op_slt:
        return inst[25:21] == r || inst[20:16] == r;
      isa_pkg::op_addi, isa_pkg::op_ori: return inst[25:21] == r;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic pair_splits(isa_pkg::inst_t i0, isa_pkg::inst_t i1);
    isa_pkg::reg_addr_t d;
    d = dest_of(i0);
    return d != '0 && reads_reg(i1, d);
  endfunction

  function automatic logic model_exec(input isa_pkg::inst_t inst,
                                      ref isa_pkg::word_t regs [`PROC_NUM_REGS],
                                      output isa_pkg::reg_addr_t rd,
                                      output isa_pkg::word_t val);
    isa_pkg::word_t a;
    isa_pkg::word_t b;
    isa_pkg::word_t imm;
    a   = regs[inst[25:21]];
    b   = regs[inst[20:16]];
    imm = {16'h0000, inst[15:0]};
    rd  = dest_of(inst);
    case (inst[31:26])
      isa_pkg::op_add:  val = a + b;
      isa_pkg::op_sub:  val = a - b;
      isa_pkg::op_and:  val = a & b;
      isa_pkg::op_or:   val = a | b;
      isa_pkg::op_xor:  val = a ^ b;
      isa_pkg::op_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      isa_pkg::op_addi: val = a + imm;
      isa_pkg::op_ori:  val = a | imm;
      default:          val = '0;
    endcase
    if (rd != '0)
      regs[rd] = val;
    return rd != '0;
  endfunction

  function automatic isa_pkg::inst_t r_inst(logic [5:0] op, int rd, int rs, int rt);
    return {op, 5'(rs), 5'(rt), 5'(rd), 11'h000};
  endfunction

  function automatic isa_pkg::inst_t i_inst(logic [5:0] op, int rt, int rs, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  // two of the ten codes are no-ops
  function automatic isa_pkg::inst_t random_inst();
    logic [5:0]     op;
    isa_pkg::inst_t inst;
    case ($urandom_range(0, 9))
      0: op = isa_pkg::op_add;
      1: op = isa_pkg::op_sub;
      2: op = isa_pkg::op_and;
      3: op = isa_pkg::op_or;
      4: op = isa_pkg::op_xor;
      5: op = isa_pkg::op_slt;
      6: op = isa_pkg::op_addi;
      7: op = isa_pkg::op_ori;
      8: op = 6'h00;
      default: op = 6'h3f;
    endcase
    inst[31:26] = op;
    inst[25:21] = 5'($urandom_range(0, 7));
    inst[20:16] = 5'($urandom_range(0, 7));
    inst[15:11] = 5'($urandom_range(0, 7));
    inst[10:0]  = 11'($urandom);
    if (op == isa_pkg::op_addi || op == isa_pkg::op_ori)
      inst[15:0] = 16'($urandom);
    return inst;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // driver
  //////////////////////////////////////////////////////////////////////

  task automatic check_stall();
    checks++;
    assert (issue_stall == stall_due) else begin
      errors++;
      $display("FAILED %s: issue_stall expected %0d actual %0d",
               test_name, stall_due, issue_stall);
    end
  endtask

  task automatic expect_write(isa_pkg::inst_t inst, int unsigned due);
    expected_write_t    e;
    isa_pkg::reg_addr_t rd;
    isa_pkg::word_t     val;
    if (model_exec(inst, model_regs, rd, val)) begin
      e.rd   = rd;
      e.data = val;
      e.due  = due;
      exp_q.push_back(e);
    end
  endtask

  task automatic send_pair(isa_pkg::inst_t i0, isa_pkg::inst_t i1);
    int unsigned waits;
    int unsigned accept_cycle;
    logic        split;
    @(negedge clk);
    check_stall();
    bundle_valid = 1'b1;
    bundle[0]    = i0;
    bundle[1]    = i1;
    waits        = 0;
    // hold the pair while the steer replays
    while (issue_stall) begin
      @(negedge clk);
      waits++;
    end
    checks++;
    assert (waits == stall_due) else begin
      errors++;
      $display("FAILED %s: stall cycles expected %0d actual %0d", test_name, stall_due, waits);
    end
    accept_cycle = cycle;
    split        = pair_splits(i0, i1);
    stall_due    = split;
    @(posedge clk);
    expect_write(i0, accept_cycle + 3);
    expect_write(i1, accept_cycle + (split ? 4 : 3));
  endtask

  task automatic go_idle();
    @(negedge clk);
    check_stall();
    bundle_valid = 1'b0;
    stall_due    = 1'b0;
  endtask

  task automatic start_test(string name);
    test_name    = name;
    test_errors0 = errors;
    test_checks0 = checks;
  endtask

  task automatic finish_test();
    go_idle();
    while (exp_q.size() != 0)
      @(posedge clk);
    // a few more cycles to catch a stray writeback
    repeat (6) @(negedge clk);
    tests_run++;
    $display("test %-18s %0d checks, %0d errors",
             test_name, checks - test_checks0, errors - test_errors0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // writeback compare in program order with lane 0 first
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare_wb
    expected_write_t e;
    if (!reset) begin
      for (int l = 0; l < `PROC_NUM_LANES; l++) begin
        if (wb[l].valid) begin
          checks++;
          assert (exp_q.size() != 0) else begin
            errors++;
            $display("ERROR %s: lane %0d wrote r%0d while no write was expected",
                     test_name, l, wb[l].rd);
          end
          if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            checks++;
            assert (wb[l].rd == e.rd) else begin
              errors++;
              $display("FAILED %s: lane %0d rd expected r%0d actual r%0d",
                       test_name, l, e.rd, wb[l].rd);
            end
            checks++;
            assert (wb[l].data == e.data) else begin
              errors++;
              $display("FAILED %s: r%0d data expected 0x%08h actual 0x%08h",
                       test_name, e.rd, e.data, wb[l].data);
            end
            checks++;
            assert (cycle == e.due) else begin
              errors++;
              $display("FAILED %s: r%0d arrival cycle expected %0d actual %0d",
                       test_name, e.rd, e.due, cycle);
            end
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_idle_pairs();
    start_test("reset_idle");
    repeat (4) begin
      @(negedge clk);
      checks++;
      assert (!issue_stall && !wb[0].valid && !wb[1].valid) else begin
        errors++;
        $display("ERROR %s: issue_stall or a wb valid went high before any pair was sent",
                 test_name);
      end
    end
    send_pair(i_inst(isa_pkg::op_addi, 1, 0, 16'h0011), i_inst(isa_pkg::op_ori, 2, 0, 16'h00f0));
    send_pair(i_inst(isa_pkg::op_addi, 3, 0, 16'h7fff), i_inst(isa_pkg::op_addi, 4, 0, 16'h8000));
    send_pair(r_inst(isa_pkg::op_add, 5, 1, 2), r_inst(isa_pkg::op_sub, 6, 3, 4));
    send_pair(r_inst(isa_pkg::op_and, 7, 3, 4), r_inst(isa_pkg::op_xor, 8, 1, 3));
    // r6 is negative here
    send_pair(r_inst(isa_pkg::op_or, 9, 2, 4), r_inst(isa_pkg::op_slt, 10, 6, 1));
    finish_test();
  endtask

  task automatic back_to_back_deps();
    start_test("back_to_back_deps");
    send_pair(i_inst(isa_pkg::op_addi, 1, 0, 16'h0101), i_inst(isa_pkg::op_addi, 2, 0, 16'h0202));
    send_pair(r_inst(isa_pkg::op_add, 3, 1, 2), r_inst(isa_pkg::op_sub, 4, 2, 1));
    // both lanes write r5
    send_pair(r_inst(isa_pkg::op_xor, 5, 3, 4), r_inst(isa_pkg::op_or, 5, 4, 4));
    send_pair(r_inst(isa_pkg::op_add, 6, 5, 0), r_inst(isa_pkg::op_and, 7, 5, 3));
    send_pair(i_inst(isa_pkg::op_ori, 8, 5, 16'h1000), r_inst(isa_pkg::op_slt, 9, 4, 5));
    finish_test();
  endtask

  task automatic intra_pair_split();
    start_test("intra_pair_split");
    send_pair(i_inst(isa_pkg::op_addi, 13, 1, 16'h0010), r_inst(isa_pkg::op_add, 14, 13, 2));
    send_pair(r_inst(isa_pkg::op_add, 16, 14, 13), i_inst(isa_pkg::op_addi, 17, 16, 16'h0001));
    send_pair(r_inst(isa_pkg::op_sub, 18, 2, 1), r_inst(isa_pkg::op_and, 19, 1, 18));
    // rt of an addi is its destination and causes no split
    send_pair(i_inst(isa_pkg::op_addi, 20, 0, 16'h0003),
              i_inst(isa_pkg::op_addi, 20, 1, 16'h0001));
    finish_test();
  endtask

  task automatic r0_and_nops();
    start_test("r0_and_nops");
    send_pair(r_inst(isa_pkg::op_add, 0, 1, 2), i_inst(isa_pkg::op_addi, 0, 1, 16'h0005));
    send_pair(r_inst(6'h00, 3, 1, 2), r_inst(6'h3f, 4, 3, 3));
    send_pair(r_inst(6'h07, 21, 1, 1), r_inst(isa_pkg::op_add, 22, 21, 1));
    send_pair(r_inst(isa_pkg::op_add, 11, 0, 1), i_inst(isa_pkg::op_ori, 12, 0, 16'h1234));
    finish_test();
  endtask

  task automatic random_programs();
    isa_pkg::inst_t i0;
    isa_pkg::inst_t i1;
    start_test("random_programs");
    for (int n = 0; n < RANDOM_PAIRS; n++) begin
      i0 = random_inst();
      i1 = random_inst();
      send_pair(i0, i1);
    end
    finish_test();
  endtask

  initial begin
    void'($urandom(73101));
    reset        = 1'b1;
    bundle_valid = 1'b0;
    bundle       = '0;
    stall_due    = 1'b0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    test_name    = "reset";
    for (int r = 0; r < `PROC_NUM_REGS; r++)
      model_regs[r] = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    reset_idle_pairs();
    back_to_back_deps();
    intra_pair_split();
    r0_and_nops();
    random_programs();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
